// File: hw/chn_pkg.sv
/* Channel package
   Widths, TLP fields, register map and arbiter states of the DMA channel */

`default_nettype none

package chn_pkg;

    // ------------------------------
    // Data widths
    // ------------------------------
    typedef logic [63:0] qword_t;                 // TRN or MAC data beat
    typedef logic [63:0] host_addr_t;             // Host byte address
    typedef logic [15:0] cpl_id_t;                // Bus, device, function
    typedef logic [9:0]  len_dw_t;                // TLP length in dwords
    typedef logic [7:0]  thr_t;                   // Irq threshold or frame count

    // ------------------------------
    // Arbiter
    // ------------------------------
    typedef enum logic [1:0] {
        ARB_IDLE,                                 // Waiting for a request and a turn
        ARB_RX,                                   // rx_wr owns the bus
        ARB_IRQ                                   // irq_gen owns the turn
    } arb_state_t;

    // ------------------------------
    // TLP and BAR
    // ------------------------------
    localparam logic [7:0] FMT_MWR64 = 8'h60;     // 4DW header memory write
    localparam int         CHN_BAR   = 2;         // BAR hit bit for the register window

    // Frame buffer
    localparam int RX_DEPTH = 32;                 // Qwords
    localparam int RX_AW    = $clog2(RX_DEPTH);   // Buffer index width

    // Register offsets as qword index from address bits 5:3
    localparam logic [2:0] REG_RX_ADDR = 3'd0;    // Host base address
    localparam logic [2:0] REG_IRQ_EN  = 3'd1;    // Bit 0 enables the interrupt
    localparam logic [2:0] REG_IRQ_THR = 3'd2;    // Frames per interrupt

endpackage

`default_nettype wire

// File: hw/chn_regs.sv
/* Channel registers
   Decodes host memory writes on the TRN receive bus into the channel registers */

`timescale 1ns/1ns
`default_nettype none

module chn_regs (
    input  wire                 pcie_clk,
    input  wire                 rst_n,
    input  wire chn_pkg::qword_t trn_rd,
    input  wire                 trn_rsof_n,
    input  wire                 trn_reof_n,
    input  wire                 trn_rsrc_rdy_n,
    input  wire [6:0]           trn_rbar_hit_n,
    output chn_pkg::host_addr_t rx_base_addr,
    output logic                irq_en,
    output chn_pkg::thr_t       irq_thr
);

    logic [1:0] beat_cnt;                         // 1 addr, 2 data, 3 skip
    logic       hdr_ok;                           // Format and BAR matched on sof
    logic [2:0] reg_off;                          // Register offset from addr beat

    always_ff @(posedge pcie_clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt     <= 2'd0;
            hdr_ok       <= 1'b0;
            reg_off      <= 3'd0;
            rx_base_addr <= '0;
            irq_en       <= 1'b0;
            irq_thr      <= '0;
        end else if (!trn_rsrc_rdy_n) begin
            if (!trn_rsof_n) begin
                beat_cnt <= 2'd1;
                hdr_ok   <= (trn_rd[63:56] == chn_pkg::FMT_MWR64) &&
                            !trn_rbar_hit_n[chn_pkg::CHN_BAR];
            end else begin
                if (beat_cnt == 2'd1)
                    reg_off <= trn_rd[5:3];       // Low addr dword sits in bits 31:0
                // Data beat closes a three beat write
                if (beat_cnt == 2'd2 && hdr_ok && !trn_reof_n) begin
                    case (reg_off)
                        chn_pkg::REG_RX_ADDR: rx_base_addr <= trn_rd;
                        chn_pkg::REG_IRQ_EN:  irq_en       <= trn_rd[0];
                        chn_pkg::REG_IRQ_THR: irq_thr      <= trn_rd[7:0];
                        default: ;                // Unmapped offset
                    endcase
                end
                if (!trn_reof_n)
                    beat_cnt <= 2'd0;
                else if (beat_cnt == 2'd1 || beat_cnt == 2'd2)
                    beat_cnt <= beat_cnt + 2'd1;  // Holds at 3 until eof
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/chn_arb.sv
/* Channel arbiter
   Asks the endpoint for a turn and hands it to rx_wr or irq_gen, alternating */

`timescale 1ns/1ns
`default_nettype none

module chn_arb (
    input  wire  pcie_clk,
    input  wire  rst_n,
    input  wire  chn_trn,
    output logic chn_reqep,
    output logic chn_drvn,
    output logic rx_trn,
    output logic irq_trn,
    input  wire  rx_reqep,
    input  wire  rx_drvn,
    input  wire  irq_reqep,
    input  wire  irq_drvn
);

    chn_pkg::arb_state_t state;
    logic                last_rx;                 // rx_wr won the previous turn
    logic                pick_rx;

    // rx_wr wins unless both ask and it won last time
    assign pick_rx   = rx_reqep && (!irq_reqep || !last_rx);

    assign chn_reqep = (state == chn_pkg::ARB_IDLE) && (rx_reqep || irq_reqep);
    assign chn_drvn  = (state != chn_pkg::ARB_IDLE);

    // ------------------------------
    // Grant FSM
    // ------------------------------
    always_ff @(posedge pcie_clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= chn_pkg::ARB_IDLE;
            last_rx <= 1'b0;
            rx_trn  <= 1'b0;
            irq_trn <= 1'b0;
        end else begin
            rx_trn  <= 1'b0;                      // One cycle pulses
            irq_trn <= 1'b0;
            case (state)
                chn_pkg::ARB_IDLE: begin
                    if (chn_trn && (rx_reqep || irq_reqep)) begin
                        if (pick_rx) begin
                            state   <= chn_pkg::ARB_RX;
                            rx_trn  <= 1'b1;
                            last_rx <= 1'b1;
                        end else begin
                            state   <= chn_pkg::ARB_IRQ;
                            irq_trn <= 1'b1;
                            last_rx <= 1'b0;
                        end
                    end
                end
                // drv_ep rises the cycle after my_trn, so wait past the pulse
                chn_pkg::ARB_RX: begin
                    if (!rx_trn && !rx_drvn)
                        state <= chn_pkg::ARB_IDLE;
                end
                chn_pkg::ARB_IRQ: begin
                    if (!irq_trn && !irq_drvn)
                        state <= chn_pkg::ARB_IDLE;
                end
                default: state <= chn_pkg::ARB_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/rx_wr.sv
/* Receive write engine
   Buffers one MAC frame and writes it to host memory as a single MWr64 TLP */

`timescale 1ns/1ns
`default_nettype none

module rx_wr (
    input  wire                      pcie_clk,
    input  wire                      rst_n,
    input  wire chn_pkg::qword_t     mac_rx_data,
    input  wire [7:0]                mac_rx_data_valid,
    input  wire                      mac_rx_good_frame,
    input  wire                      mac_rx_bad_frame,
    input  wire chn_pkg::host_addr_t rx_base_addr,
    input  wire chn_pkg::cpl_id_t    cpl_id,
    output chn_pkg::qword_t          trn_td,
    output logic                     trn_tsof_n,
    output logic                     trn_teof_n,
    output logic                     trn_tsrc_rdy_n,
    input  wire                      trn_tdst_rdy_n,
    input  wire                      my_trn,
    output logic                     req_ep,
    output logic                     drv_ep,
    output logic                     frame_done
);

    localparam int AW = chn_pkg::RX_AW;

    chn_pkg::qword_t     mem [chn_pkg::RX_DEPTH]; // Frame buffer
    logic [AW:0]         wr_cnt;                  // Beats of the frame so far
    logic [AW:0]         frame_qw;                // Held frame length
    logic [AW:0]         nxt;                     // Next TLP beat to load
    logic [AW:0]         rd_idx;
    logic                busy;                    // Frame held until its eof is taken
    logic                discard;                 // Rest of this frame is dropped
    chn_pkg::host_addr_t run_addr;                // Running host address
    chn_pkg::host_addr_t base_q;                  // Last seen base register
    chn_pkg::len_dw_t    len_dw;
    chn_pkg::qword_t     hdr0;
    logic                frame_end;
    logic                beat_in;
    logic                beat_wr;
    logic                tx_ack;
    logic                last_ack;

    assign frame_end = mac_rx_good_frame || mac_rx_bad_frame;
    assign beat_in   = (mac_rx_data_valid != 8'h00) && !frame_end;
    assign beat_wr   = beat_in && !busy && !discard && (wr_cnt != chn_pkg::RX_DEPTH);

    assign len_dw    = chn_pkg::len_dw_t'(frame_qw) << 1;   // Two dwords per qword
    assign hdr0      = {chn_pkg::FMT_MWR64, 14'd0, len_dw, cpl_id, 8'h00, 8'hff};

    assign tx_ack    = drv_ep && !trn_tsrc_rdy_n && !trn_tdst_rdy_n;
    assign last_ack  = tx_ack && !trn_teof_n;
    assign rd_idx    = nxt - (AW + 1)'(2);        // Payload follows two header beats

    // ------------------------------
    // Frame capture
    // ------------------------------
    always_ff @(posedge pcie_clk) begin
        if (beat_wr)
            mem[wr_cnt[AW-1:0]] <= mac_rx_data;
    end

    always_ff @(posedge pcie_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt   <= '0;
            frame_qw <= '0;
            discard  <= 1'b0;
            busy     <= 1'b0;
            req_ep   <= 1'b0;
        end else begin
            if (frame_end) begin
                wr_cnt  <= '0;
                discard <= 1'b0;
                if (mac_rx_good_frame && !mac_rx_bad_frame && !busy && !discard &&
                    wr_cnt != '0) begin
                    frame_qw <= wr_cnt;
                    busy     <= 1'b1;
                    req_ep   <= 1'b1;             // Ask for a turn next cycle
                end
            end else if (beat_in) begin
                if (beat_wr)
                    wr_cnt <= wr_cnt + 1'b1;
                else
                    discard <= 1'b1;              // Buffer busy or frame too long
            end
            if (my_trn)
                req_ep <= 1'b0;
            if (last_ack)
                busy <= 1'b0;
        end
    end

    // ------------------------------
    // TLP send
    // ------------------------------
    always_ff @(posedge pcie_clk or negedge rst_n) begin
        if (!rst_n) begin
            trn_td         <= '0;
            trn_tsof_n     <= 1'b1;
            trn_teof_n     <= 1'b1;
            trn_tsrc_rdy_n <= 1'b1;
            drv_ep         <= 1'b0;
            nxt            <= '0;
            frame_done     <= 1'b0;
            run_addr       <= '0;
            base_q         <= '0;
        end else begin
            frame_done <= 1'b0;
            if (my_trn) begin
                trn_td         <= hdr0;           // Header qword 0 right after the grant
                trn_tsof_n     <= 1'b0;
                trn_teof_n     <= 1'b1;
                trn_tsrc_rdy_n <= 1'b0;
                drv_ep         <= 1'b1;
                nxt            <= (AW + 1)'(1);
            end else if (last_ack) begin
                trn_td         <= '0;             // Idle bus is zero for the OR merge
                trn_tsof_n     <= 1'b1;
                trn_teof_n     <= 1'b1;
                trn_tsrc_rdy_n <= 1'b1;
                drv_ep         <= 1'b0;
                frame_done     <= 1'b1;
            end else if (tx_ack) begin
                trn_tsof_n <= 1'b1;
                trn_teof_n <= !(nxt == frame_qw + 1'b1);
                trn_td     <= (nxt == (AW + 1)'(1)) ? run_addr : mem[rd_idx[AW-1:0]];
                nxt        <= nxt + 1'b1;
            end                                   // Else hold the beat

            // Base register write restarts the address sequence
            if (rx_base_addr != base_q) begin
                base_q   <= rx_base_addr;
                run_addr <= rx_base_addr;
            end else if (last_ack) begin
                run_addr <= run_addr + (chn_pkg::host_addr_t'(frame_qw) << 3);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/irq_gen.sv
/* Interrupt generator
   Counts written frames and raises a PCIe interrupt at the threshold */

`timescale 1ns/1ns
`default_nettype none

module irq_gen (
    input  wire                pcie_clk,
    input  wire                rst_n,
    input  wire                frame_done,
    input  wire                irq_en,
    input  wire chn_pkg::thr_t irq_thr,
    input  wire                cfg_interrupt_rdy_n,
    output logic               cfg_interrupt_n,
    input  wire                my_trn,
    output logic               req_ep,
    output logic               drv_ep
);

    chn_pkg::thr_t frm_cnt;                       // Frames since the last interrupt
    logic          thr_hit;
    logic          irq_ack;

    assign thr_hit = irq_en && (irq_thr != '0) && (frm_cnt >= irq_thr);
    assign irq_ack = drv_ep && !cfg_interrupt_n && !cfg_interrupt_rdy_n;

    always_ff @(posedge pcie_clk or negedge rst_n) begin
        if (!rst_n) begin
            frm_cnt         <= '0;
            req_ep          <= 1'b0;
            drv_ep          <= 1'b0;
            cfg_interrupt_n <= 1'b1;
        end else begin
            if (irq_ack) begin
                cfg_interrupt_n <= 1'b1;
                drv_ep          <= 1'b0;
                frm_cnt         <= chn_pkg::thr_t'(frame_done);   // Keep a same-cycle frame
            end else if (frame_done && frm_cnt != '1) begin
                frm_cnt <= frm_cnt + 1'b1;        // Saturating
            end

            // Going through the arbiter puts the irq after granted writes
            if (my_trn) begin
                req_ep          <= 1'b0;
                drv_ep          <= 1'b1;
                cfg_interrupt_n <= 1'b0;          // Held until the core takes it
            end else if (thr_hit && !req_ep && !drv_ep) begin
                req_ep <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/chn.sv
/* DMA channel top
   Register decode, receive write engine, interrupt and arbiter on pcie_clk */

`timescale 1ns/1ns
`default_nettype none

module chn (
    input  wire                  pcie_clk,
    input  wire                  rst_n,

    // MAC rx
    input  wire chn_pkg::qword_t mac_rx_data,
    input  wire [7:0]            mac_rx_data_valid,
    input  wire                  mac_rx_good_frame,
    input  wire                  mac_rx_bad_frame,

    // TRN tx
    output wire chn_pkg::qword_t trn_td,
    output wire [7:0]            trn_trem_n,
    output wire                  trn_tsof_n,
    output wire                  trn_teof_n,
    output wire                  trn_tsrc_rdy_n,
    input  wire                  trn_tdst_rdy_n,

    // TRN rx
    input  wire chn_pkg::qword_t trn_rd,
    input  wire                  trn_rsof_n,
    input  wire                  trn_reof_n,
    input  wire                  trn_rsrc_rdy_n,
    input  wire [6:0]            trn_rbar_hit_n,

    // CFG
    output wire                  cfg_interrupt_n,
    input  wire                  cfg_interrupt_rdy_n,
    input  wire [7:0]            cfg_bus_number,
    input  wire [4:0]            cfg_device_number,
    input  wire [2:0]            cfg_function_number,

    // Endpoint arbiter
    input  wire                  chn_trn,
    output wire                  chn_reqep,
    output wire                  chn_drvn
);

    // ------------------------------
    // Internal nets
    // ------------------------------
    chn_pkg::cpl_id_t    cpl_id;
    chn_pkg::host_addr_t rx_base_addr;
    logic                irq_en;
    chn_pkg::thr_t       irq_thr;
    chn_pkg::qword_t     rx_td;
    logic                rx_tsof_n;
    logic                rx_teof_n;
    logic                rx_tsrc_rdy_n;
    logic                rx_trn;
    logic                rx_reqep;
    logic                rx_drvn;
    logic                irq_trn;
    logic                irq_reqep;
    logic                irq_drvn;
    logic                frame_done;

    assign cpl_id = {cfg_bus_number, cfg_device_number, cfg_function_number};

    // irq_gen signals on cfg only, so rx_wr is the sole TRN tx source
    assign trn_td         = rx_td;
    assign trn_tsof_n     = rx_tsof_n;
    assign trn_teof_n     = rx_teof_n;
    assign trn_tsrc_rdy_n = rx_tsrc_rdy_n;
    assign trn_trem_n     = 8'h00;                // Whole qwords only

    chn_regs chn_regs_inst (
        .pcie_clk(pcie_clk), .rst_n(rst_n),
        .trn_rd(trn_rd), .trn_rsof_n(trn_rsof_n), .trn_reof_n(trn_reof_n),
        .trn_rsrc_rdy_n(trn_rsrc_rdy_n), .trn_rbar_hit_n(trn_rbar_hit_n),
        .rx_base_addr(rx_base_addr), .irq_en(irq_en), .irq_thr(irq_thr)
    );

    rx_wr rx_wr_inst (
        .pcie_clk(pcie_clk), .rst_n(rst_n),
        .mac_rx_data(mac_rx_data), .mac_rx_data_valid(mac_rx_data_valid),
        .mac_rx_good_frame(mac_rx_good_frame), .mac_rx_bad_frame(mac_rx_bad_frame),
        .rx_base_addr(rx_base_addr), .cpl_id(cpl_id),
        .trn_td(rx_td), .trn_tsof_n(rx_tsof_n), .trn_teof_n(rx_teof_n),
        .trn_tsrc_rdy_n(rx_tsrc_rdy_n), .trn_tdst_rdy_n(trn_tdst_rdy_n),
        .my_trn(rx_trn), .req_ep(rx_reqep), .drv_ep(rx_drvn), .frame_done(frame_done)
    );

    irq_gen irq_gen_inst (
        .pcie_clk(pcie_clk), .rst_n(rst_n),
        .frame_done(frame_done), .irq_en(irq_en), .irq_thr(irq_thr),
        .cfg_interrupt_rdy_n(cfg_interrupt_rdy_n), .cfg_interrupt_n(cfg_interrupt_n),
        .my_trn(irq_trn), .req_ep(irq_reqep), .drv_ep(irq_drvn)
    );

    chn_arb chn_arb_inst (
        .pcie_clk(pcie_clk), .rst_n(rst_n),
        .chn_trn(chn_trn), .chn_reqep(chn_reqep), .chn_drvn(chn_drvn),
        .rx_trn(rx_trn), .irq_trn(irq_trn),
        .rx_reqep(rx_reqep), .rx_drvn(rx_drvn),
        .irq_reqep(irq_reqep), .irq_drvn(irq_drvn)
    );

endmodule

`default_nettype wire

// File: sim/chn_tb_tasks.svh
/* Channel directed tests
   TRN register writes, MAC frames and TLP checks for the channel testbench */

`ifndef CHN_TB_TASKS_SVH
`define CHN_TB_TASKS_SVH

task automatic expect_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    assert (got === exp) else begin
        mismatches++;
        $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic step_clock();
    @(posedge pcie_clk);
    #1;
endtask

// Three beat MWr64 on the TRN rx bus hitting BAR index bar
task automatic host_reg_write(input logic [2:0] off, input chn_pkg::qword_t data,
                              input int bar);
    chn_pkg::qword_t hdr;
    hdr        = '0;
    hdr[63:56] = chn_pkg::FMT_MWR64;
    hdr[41:32] = 10'd2;                           // One qword of data
    hdr[7:0]   = 8'hff;
    step_clock();
    trn_rd         = hdr;
    trn_rsof_n     = 1'b0;
    trn_rsrc_rdy_n = 1'b0;
    trn_rbar_hit_n = ~(7'd1 << bar);
    step_clock();
    trn_rd     = {32'd0, 26'd0, off, 3'd0};       // Low address dword
    trn_rsof_n = 1'b1;
    step_clock();
    trn_rd     = data;
    trn_reof_n = 1'b0;
    step_clock();
    trn_rd         = '0;
    trn_reof_n     = 1'b1;
    trn_rsrc_rdy_n = 1'b1;
    trn_rbar_hit_n = 7'h7f;
    step_clock();
endtask

task automatic mac_frame(input int n, input logic good);
    logic [31:0] hi;
    logic [31:0] lo;
    int          i;
    sent_q.delete();
    for (i = 0; i < n; i++) begin
        hi = $random(seed);
        lo = $random(seed);
        step_clock();
        mac_rx_data       = {hi, lo};
        mac_rx_data_valid = 8'hff;
        sent_q.push_back({hi, lo});
    end
    step_clock();
    mac_rx_data       = '0;
    mac_rx_data_valid = 8'h00;
    mac_rx_good_frame = good;
    mac_rx_bad_frame  = !good;
    step_clock();
    mac_rx_good_frame = 1'b0;
    mac_rx_bad_frame  = 1'b0;
endtask

task automatic wait_for_tlps(input int target);
    int cyc;
    cyc = 0;
    while (tlp_cnt < target && cyc < 400) begin
        step_clock();
        cyc++;
    end
    assert (tlp_cnt >= target) else begin
        failures++;
        $display("Error at %0t: timeout waiting for TLP number %0d", $time, target);
    end
endtask

// Header from the TLP rule, then address and payload
task automatic compare_tlp(input int n, input chn_pkg::host_addr_t addr);
    chn_pkg::qword_t hdr;
    int              i;
    hdr        = '0;
    hdr[63:56] = chn_pkg::FMT_MWR64;
    hdr[41:32] = 10'(2 * n);
    hdr[31:16] = {cfg_bus_number, cfg_device_number, cfg_function_number};
    hdr[7:0]   = 8'hff;
    expect_eq(tx_q.size(), n + 2, "TLP beat count");
    if (tx_q.size() == n + 2) begin
        expect_eq(tx_q[0], hdr, "header qword 0");
        expect_eq(tx_q[1], addr, "host address");
        for (i = 0; i < n; i++)
            expect_eq(tx_q[i + 2], sent_q[i], $sformatf("payload qword %0d", i));
    end
    tx_q.delete();
endtask

task automatic write_one_frame(input int n);
    int target;
    target = tlp_cnt + 1;
    mac_frame(n, 1'b1);
    wait_for_tlps(target);
    compare_tlp(n, exp_addr);
    exp_addr = exp_addr + 64'(8 * n);             // Running address moves past the frame
endtask

// ------------------------------
// Directed tests
// ------------------------------
task automatic after_reset_outputs();
    repeat (2) step_clock();
    expect_eq(chn_reqep, 1'b0, "chn_reqep after reset");
    expect_eq(chn_drvn, 1'b0, "chn_drvn after reset");
    expect_eq(trn_tsrc_rdy_n, 1'b1, "trn_tsrc_rdy_n after reset");
    expect_eq(trn_tsof_n, 1'b1, "trn_tsof_n after reset");
    expect_eq(trn_teof_n, 1'b1, "trn_teof_n after reset");
    expect_eq(trn_trem_n, 8'h00, "trn_trem_n");
    expect_eq(cfg_interrupt_n, 1'b1, "cfg_interrupt_n after reset");
endtask

task automatic irq_after_two_frames();
    int start;
    int cyc;
    host_reg_write(chn_pkg::REG_IRQ_THR, 64'd2, chn_pkg::CHN_BAR);
    host_reg_write(chn_pkg::REG_IRQ_EN, 64'd1, chn_pkg::CHN_BAR);
    exp_addr = 64'h0000_0002_8000_0000;
    host_reg_write(chn_pkg::REG_RX_ADDR, exp_addr, chn_pkg::CHN_BAR);
    start = tlp_cnt;
    write_one_frame(4);
    repeat (20) step_clock();                     // Room for an early interrupt turn
    expect_eq(irq_falls, 0, "interrupts after one frame");
    write_one_frame(6);
    cyc = 0;
    while (irq_rises == 0 && cyc < 200) begin
        step_clock();
        cyc++;
    end
    assert (irq_rises == 1) else begin
        failures++;
        $display("Error at %0t: interrupt was not raised and accepted", $time);
    end
    expect_eq(irq_falls, 1, "interrupt count");
    expect_eq(irq_fall_tlps, start + 2, "TLPs done before the interrupt");
    host_reg_write(chn_pkg::REG_IRQ_EN, 64'd0, chn_pkg::CHN_BAR);
endtask

task automatic frame_addresses();
    int start;
    exp_addr = 64'h0000_0001_2345_6000;
    host_reg_write(chn_pkg::REG_RX_ADDR, exp_addr, chn_pkg::CHN_BAR);
    write_one_frame(5);
    write_one_frame(3);
    start = tlp_cnt;
    mac_frame(4, 1'b0);                           // Bad frame is dropped
    repeat (60) step_clock();
    expect_eq(tlp_cnt, start, "TLP count after a bad frame");
    expect_eq(tx_q.size(), 0, "beats after a bad frame");
endtask

task automatic random_back_pressure();
    bp_on = 1'b1;
    write_one_frame(8);
    write_one_frame(1);
    bp_on = 1'b0;
    repeat (2) step_clock();
endtask

task automatic foreign_bar_ignored();
    host_reg_write(chn_pkg::REG_RX_ADDR, 64'h0000_00ff_dead_0000, 0);
    write_one_frame(2);                           // Still the running address
endtask

`endif

// File: sim/chn_tb.sv
/* Channel testbench
   Clock, reset, DUT, endpoint and interrupt responders and the TRN tx monitor */

`timescale 1ns/1ns
`default_nettype none

module chn_tb;

    logic                pcie_clk;
    logic                rst_n;
    chn_pkg::qword_t     mac_rx_data;
    logic [7:0]          mac_rx_data_valid;
    logic                mac_rx_good_frame;
    logic                mac_rx_bad_frame;
    chn_pkg::qword_t     trn_td;
    logic [7:0]          trn_trem_n;
    logic                trn_tsof_n;
    logic                trn_teof_n;
    logic                trn_tsrc_rdy_n;
    logic                trn_tdst_rdy_n;
    chn_pkg::qword_t     trn_rd;
    logic                trn_rsof_n;
    logic                trn_reof_n;
    logic                trn_rsrc_rdy_n;
    logic [6:0]          trn_rbar_hit_n;
    logic                cfg_interrupt_n;
    logic                cfg_interrupt_rdy_n;
    logic [7:0]          cfg_bus_number;
    logic [4:0]          cfg_device_number;
    logic [2:0]          cfg_function_number;
    logic                chn_trn;
    logic                chn_reqep;
    logic                chn_drvn;

    int                  mismatches;
    int                  failures;
    int                  seed;
    int                  tlp_cnt;                 // TLPs closed by eof
    int                  irq_falls;
    int                  irq_rises;
    int                  irq_fall_tlps;           // tlp_cnt when the interrupt fell
    int                  irq_low;                 // Cycles with the interrupt pending
    logic                in_tlp;
    logic                bp_on;                   // Random back-pressure enable
    logic                bp_bit;
    logic [31:0]         bp_rnd;
    logic                prev_irq_n;
    logic                prev_rdy_n;
    chn_pkg::host_addr_t exp_addr;                // Next expected host address
    chn_pkg::qword_t     tx_q[$];                 // Accepted TRN tx beats
    chn_pkg::qword_t     sent_q[$];               // Payload of the last MAC frame

    chn chn_inst (.*);

    always #4 pcie_clk = ~pcie_clk;

    // ------------------------------
    // Responders
    // ------------------------------
    always @(posedge pcie_clk) begin
        #1;
        chn_trn = chn_reqep && !chn_trn;          // One cycle turn pulse
        trn_tdst_rdy_n = bp_bit;
        if (!cfg_interrupt_n) begin
            irq_low = irq_low + 1;
            cfg_interrupt_rdy_n = (irq_low < 3);  // Core takes it a few cycles later
        end else begin
            irq_low = 0;
            cfg_interrupt_rdy_n = 1'b1;
        end
    end

    always @(negedge pcie_clk) begin
        bp_rnd = $random(seed);
        bp_bit = bp_on && bp_rnd[0];
    end

    // ------------------------------
    // Monitor sampling mid-cycle
    // ------------------------------
    always @(negedge pcie_clk) begin
        if (rst_n && !trn_tsrc_rdy_n && !trn_tdst_rdy_n) begin
            assert (in_tlp == trn_tsof_n) else begin
                failures++;
                $display("Error at %0t: sof out of place on the TRN tx bus", $time);
            end
            tx_q.push_back(trn_td);               // Transfers on the coming edge
            in_tlp = trn_teof_n;
            if (!trn_teof_n)
                tlp_cnt++;
        end
        if (prev_irq_n && !cfg_interrupt_n) begin
            irq_falls++;
            irq_fall_tlps = tlp_cnt;
        end
        if (!prev_irq_n && cfg_interrupt_n) begin
            assert (!prev_rdy_n) else begin
                failures++;
                $display("Error at %0t: interrupt dropped before it was accepted", $time);
            end
            irq_rises++;
        end
        prev_irq_n = cfg_interrupt_n;
        prev_rdy_n = cfg_interrupt_rdy_n;
    end

`include "chn_tb_tasks.svh"

    initial begin
        pcie_clk            = 1'b0;
        rst_n               = 1'b0;
        mac_rx_data         = '0;
        mac_rx_data_valid   = 8'h00;
        mac_rx_good_frame   = 1'b0;
        mac_rx_bad_frame    = 1'b0;
        trn_tdst_rdy_n      = 1'b0;
        trn_rd              = '0;
        trn_rsof_n          = 1'b1;
        trn_reof_n          = 1'b1;
        trn_rsrc_rdy_n      = 1'b1;
        trn_rbar_hit_n      = 7'h7f;
        cfg_interrupt_rdy_n = 1'b1;
        cfg_bus_number      = 8'h3a;
        cfg_device_number   = 5'h07;
        cfg_function_number = 3'h1;
        chn_trn             = 1'b0;
        seed                = 32'h2e8d_3db5;
        mismatches          = 0;
        failures            = 0;
        tlp_cnt             = 0;
        irq_falls           = 0;
        irq_rises           = 0;
        irq_fall_tlps       = 0;
        irq_low             = 0;
        in_tlp              = 1'b0;
        bp_on               = 1'b0;
        bp_bit              = 1'b0;
        prev_irq_n          = 1'b1;
        prev_rdy_n          = 1'b1;
        exp_addr            = '0;
        repeat (16) @(posedge pcie_clk);
        #1;
        rst_n = 1'b1;

        after_reset_outputs();
        irq_after_two_frames();                   // Needs a fresh frame count
        frame_addresses();
        random_back_pressure();
        foreign_bar_ignored();

        $display("Closing counts: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+sim
hw/chn_pkg.sv
hw/chn_regs.sv
hw/chn_arb.sv
hw/rx_wr.sv
hw/irq_gen.sv
hw/chn.sv
sim/chn_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DMA channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module chn_tb -f flist.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/Vchn_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -qx "Regression passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
